// ==== sources.f ====
+incdir+verilog
verilog/flitPkg.sv
verilog/portPkg.sv
verilog/flitLink.sv
verilog/leaseCounter.sv
verilog/outputAllocator.sv
verilog/outputPort.sv
verilog/inputUnit.sv
verilog/routerTop.sv
tests/router_properties.sv
tests/routerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= routerTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/routerTb.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module routerTb;

  localparam int NP = `NUM_PORTS;
  localparam int TX_DEPTH = 64;
  localparam int WAIT_LIMIT = 400;
  localparam int ROUTER_X = 1;
  localparam int ROUTER_Y = 1;

  logic                   clk;
  logic                   rst;
  flitPkg::flit [NP-1:0]  inFlit = '0;
  logic [NP-1:0]          inValid = '0;
  logic [NP-1:0]          inCredit;
  flitPkg::flit [NP-1:0]  outFlit;
  logic [NP-1:0]          outValid;
  logic [NP-1:0]          outCredit = '0;

  // Upstream side, one flit source per input
  flitPkg::flit  txMem [NP][TX_DEPTH];
  int            txHead [NP] = '{default: 0};
  int            txTail [NP] = '{default: 0};
  int            upCredit [NP];
  int            creditPulses = 0;

  // Downstream side, one sink per output
  logic [NP-1:0]    hold;
  int               owed [NP];
  flitPkg::flit     rxFlit [$];
  portPkg::portDir  rxPort [$];

  flitPkg::flit     expFlit [$];
  portPkg::portDir  expPort [$];
  int               rxBase;
  int               creditBase;
  int               sentCount;
  int               errors = 0;
  int               testErrors;
  int               testsPassed = 0;
  int               testsFailed = 0;

  routerTop #(
    .routerX (ROUTER_X),
    .routerY (ROUTER_Y)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .inCredit  (inCredit),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .outCredit (outCredit)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Neighbour models, credit based on both sides
  // --------------------------------------------------------------------------
  always @(posedge clk)
  begin
    if (rst)
    begin
      inValid   <= '0;
      outCredit <= '0;
      for (int i = 0; i < NP; i++)
      begin
        upCredit[i] = `BUF_DEPTH;
        owed[i]     = 0;
      end
    end
    else
    begin
      for (int i = 0; i < NP; i++)
      begin
        if (inCredit[i])
        begin
          upCredit[i]++;
          creditPulses++;
        end
        inValid[i] <= 1'b0;
        if (txHead[i] < txTail[i] && upCredit[i] > 0)
        begin
          inFlit[i]  <= txMem[i][txHead[i]];
          inValid[i] <= 1'b1;
          txHead[i]++;
          upCredit[i]--;
        end
        if (outValid[i])
        begin
          rxFlit.push_back(outFlit[i]);
          rxPort.push_back(portPkg::portDir'(i));
          owed[i]++;
        end
        // Credits pile up while the sink holds them back
        outCredit[i] <= 1'b0;
        if (!hold[i] && owed[i] > 0)
        begin
          outCredit[i] <= 1'b1;
          owed[i]--;
        end
      end
    end
  end

  task automatic checkFlit(input string name, input flitPkg::flit got, input flitPkg::flit exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkPort(input string name, input portPkg::portDir got,
                           input portPkg::portDir exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkCount(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // XY order, X first
  function automatic portPkg::portDir routeFor(input int x, input int y);
    if (x > ROUTER_X)
      return portPkg::EAST;
    if (x < ROUTER_X)
      return portPkg::WEST;
    if (y > ROUTER_Y)
      return portPkg::NORTH;
    if (y < ROUTER_Y)
      return portPkg::SOUTH;
    return portPkg::LOCAL;
  endfunction

  task automatic queuePacket(input portPkg::portDir src, input int x, input int y,
                             input int len);
    flitPkg::flit f;
    for (int k = 0; k < len; k++)
    begin
      f = '0;
      if (k == 0)
      begin
        f.kind                  = flitPkg::HEAD;
        f.payload.hdr.destX     = `COORD_W'(x);
        f.payload.hdr.destY     = `COORD_W'(y);
        f.payload.hdr.pktLength = `LEN_W'(len);
      end
      else
      begin
        f.kind         = (k == len - 1) ? flitPkg::TAIL : flitPkg::BODY;
        f.payload.data = $urandom();
      end
      txMem[src][txTail[src]] = f;
      txTail[src]++;
      expFlit.push_back(f);
      expPort.push_back(routeFor(x, y));
    end
    sentCount += len;
  endtask

  task automatic waitRx(input int n, input string what);
    int cycles;
    cycles = 0;
    while (rxFlit.size() - rxBase < n && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (rxFlit.size() - rxBase < n)
    begin
      $display("Timeout in %s: only %0d of %0d flits arrived", what, rxFlit.size() - rxBase, n);
      errors++;
    end
  endtask

  task automatic waitCredits(input string what);
    int cycles;
    cycles = 0;
    while (creditPulses - creditBase < sentCount && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (creditPulses - creditBase < sentCount)
    begin
      $display("Timeout in %s: credits were not all returned upstream", what);
      errors++;
    end
    else
      checkCount("inCredit pulses", 32'(creditPulses - creditBase), 32'(sentCount));
  endtask

  // Each output must see its own flits in send order
  task automatic compareStreams();
    flitPkg::flit want [$];
    flitPkg::flit seen [$];
    for (int o = 0; o < NP; o++)
    begin
      want.delete();
      seen.delete();
      foreach (expFlit[k])
        if (int'(expPort[k]) == o)
          want.push_back(expFlit[k]);
      for (int k = rxBase; k < rxFlit.size(); k++)
        if (int'(rxPort[k]) == o)
          seen.push_back(rxFlit[k]);
      checkCount($sformatf("flit count on output %0d", o), seen.size(), want.size());
      for (int k = 0; k < want.size() && k < seen.size(); k++)
        checkFlit($sformatf("outFlit[%0d] flit %0d", o, k), seen[k], want[k]);
    end
  endtask

  task automatic startTest();
    rxBase     = rxFlit.size();
    creditBase = creditPulses;
    sentCount  = 0;
    testErrors = errors;
    expFlit.delete();
    expPort.delete();
  endtask

  task automatic finishTest(input string name);
    repeat (4) @(negedge clk);
    if (errors == testErrors)
    begin
      $display("PASS %s", name);
      testsPassed++;
    end
    else
    begin
      $display("FAIL %s (%0d errors)", name, errors - testErrors);
      testsFailed++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic idleAfterReset();
    startTest();
    for (int c = 0; c < 10; c++)
    begin
      @(negedge clk);
      checkCount("outValid", 32'(outValid), 0);
      checkCount("inCredit", 32'(inCredit), 0);
    end
    finishTest("reset state");
  endtask

  task automatic xyRouting();
    int xs [5];
    int ys [5];
    portPkg::portDir ports [5];
    xs    = '{3, 0, 1, 1, 1};
    ys    = '{1, 1, 2, 0, 1};
    ports = '{portPkg::EAST, portPkg::WEST, portPkg::NORTH, portPkg::SOUTH, portPkg::LOCAL};
    startTest();
    for (int j = 0; j < 5; j++)
    begin
      queuePacket(portPkg::LOCAL, xs[j], ys[j], 3);
      waitRx(3 * (j + 1), "XY routing");
      if (rxFlit.size() - rxBase > 3 * j)
        checkPort("header output", rxPort[rxBase + 3 * j], ports[j]);
      waitCredits("XY routing");
    end
    compareStreams();
    finishTest("XY routing");
  endtask

  task automatic noInterleave();
    startTest();
    queuePacket(portPkg::NORTH, 3, 1, 5);
    queuePacket(portPkg::WEST, 3, 1, 3);
    waitRx(8, "no interleaving");
    waitCredits("no interleaving");
    compareStreams();
    finishTest("no interleaving");
  endtask

  // Expected EAST order is Local, North, South, then around again
  task automatic rotatingGrant();
    startTest();
    for (int r = 0; r < 2; r++)
    begin
      queuePacket(portPkg::LOCAL, 3, 1, 3);
      queuePacket(portPkg::NORTH, 3, 1, 3);
      queuePacket(portPkg::SOUTH, 3, 1, 3);
    end
    waitRx(18, "rotation");
    waitCredits("rotation");
    compareStreams();
    finishTest("rotation");
  endtask

  task automatic backPressure();
    startTest();
    hold[portPkg::EAST] = 1'b1;
    queuePacket(portPkg::LOCAL, 3, 1, 8);
    waitRx(`BUF_DEPTH, "back-pressure");
    for (int c = 0; c < 20; c++)
    begin
      @(negedge clk);
      checkCount("outValid[EAST]", 32'(outValid[portPkg::EAST]), 0);
    end
    checkCount("flits under back-pressure", 32'(rxFlit.size() - rxBase), `BUF_DEPTH);
    hold[portPkg::EAST] = 1'b0;
    waitRx(8, "back-pressure");
    waitCredits("back-pressure");
    compareStreams();
    finishTest("back-pressure");
  endtask

  task automatic parallelPaths();
    startTest();
    queuePacket(portPkg::LOCAL, 3, 1, 4);
    queuePacket(portPkg::WEST, 1, 2, 4);
    waitRx(8, "parallel paths");
    waitCredits("parallel paths");
    compareStreams();
    finishTest("parallel paths");
  endtask

  initial
  begin
    void'($urandom(32'hd3e7));
    rst  = 1'b1;
    hold = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    idleAfterReset();
    xyRouting();
    noInterleave();
    rotatingGrant();
    backPressure();
    parallelPaths();
    $display("Tests passing: %0d, tests failing: %0d", testsPassed, testsFailed);
    if (errors == 0 && testsFailed == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== tests/router_properties.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module routerProperties (
  input logic                  clk,
  input logic                  rst,
  input portPkg::portVec       grant,
  input portPkg::portVec       pop,
  input logic                  outValid,
  input logic [`CREDIT_W-1:0]  credit
);

  // At most one input holds the output
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is not one-hot: %b", grant);

  // Nothing moved, so the lease cannot have ended
  grantHeld: assert property (@(posedge clk) disable iff (rst)
    (grant != '0 && pop == '0) |=> grant == $past(grant))
    else $error("grant changed during an unfinished lease");

  creditGate: assert property (@(posedge clk) disable iff (rst)
    $rose(outValid) |-> $past(credit) != '0)
    else $error("outValid rose with zero credit");

  resetQuiet: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high in the cycle after reset");

endmodule

bind outputPort routerProperties uProps (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .pop      (pop),
  .outValid (outValid),
  .credit   (credit)
);

// ==== verilog/routerTop.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module routerTop #(
  parameter int routerX = 1,
  parameter int routerY = 1
) (
  input  logic                                clk,
  input  logic                                rst,
  input  flitPkg::flit [`NUM_PORTS-1:0]       inFlit,
  input  logic [`NUM_PORTS-1:0]               inValid,
  output logic [`NUM_PORTS-1:0]               inCredit,
  output flitPkg::flit [`NUM_PORTS-1:0]       outFlit,
  output logic [`NUM_PORTS-1:0]               outValid,
  input  logic [`NUM_PORTS-1:0]               outCredit
);

  flitLink link [`NUM_PORTS] ();

  // popMat[o][i] is set when output o forwards a flit from input i
  portPkg::portVec popMat [`NUM_PORTS];
  portPkg::portVec popCol [`NUM_PORTS];

  genvar i, o;
  generate
    for (i = 0; i < `NUM_PORTS; i++)
    begin : genIn
      for (o = 0; o < `NUM_PORTS; o++)
      begin : genCol
        assign popCol[i][o] = popMat[o][i];
      end

      inputUnit #(
        .routerX (routerX),
        .routerY (routerY)
      ) uIn (
        .clk      (clk),
        .rst      (rst),
        .inFlit   (inFlit[i]),
        .inValid  (inValid[i]),
        .pop      (popCol[i]),
        .inCredit (inCredit[i]),
        .link     (link[i])
      );
    end

    for (o = 0; o < `NUM_PORTS; o++)
    begin : genOut
      outputPort uOut (
        .clk       (clk),
        .rst       (rst),
        .links     (link),
        .myPort    (portPkg::portDir'(o)),
        .outFlit   (outFlit[o]),
        .outValid  (outValid[o]),
        .outCredit (outCredit[o]),
        .pop       (popMat[o])
      );
    end
  endgenerate

endmodule

// ==== verilog/inputUnit.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module inputUnit #(
  parameter int routerX = 1,
  parameter int routerY = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  flitPkg::flit     inFlit,
  input  logic             inValid,
  input  portPkg::portVec  pop,
  output logic             inCredit,
  flitLink.src             link
);

  localparam int PTR_W = $clog2(`BUF_DEPTH);
  localparam logic [`COORD_W-1:0] myX = `COORD_W'(routerX);
  localparam logic [`COORD_W-1:0] myY = `COORD_W'(routerY);

  flitPkg::flit          fifo [`BUF_DEPTH];
  logic [PTR_W-1:0]      wrPtr;
  logic [PTR_W-1:0]      rdPtr;
  logic [`CREDIT_W-1:0]  count;
  logic                  popNow;
  logic                  isHead;
  flitPkg::headerFields  hdr;
  logic [`LEN_W-1:0]     headLen;
  portPkg::portVec       xyRoute;
  logic                  routeValid;
  portPkg::portVec       heldRoute;
  logic [`LEN_W-1:0]     remaining;

  // ------------------------------------------------------------------------
  // Flit buffer, upstream credit keeps it from overflowing
  // ------------------------------------------------------------------------
  assign popNow = |pop;

  always_ff @(posedge clk)
  begin
    if (inValid)
      fifo[wrPtr] <= inFlit;
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      inCredit <= 1'b0;
    end
    else
    begin
      if (inValid)
        wrPtr <= wrPtr + 1'b1;
      if (popNow)
        rdPtr <= rdPtr + 1'b1;
      count    <= count + `CREDIT_W'(inValid) - `CREDIT_W'(popNow);
      inCredit <= popNow;
    end
  end

  // ------------------------------------------------------------------------
  // XY route of the header at the head
  // ------------------------------------------------------------------------
  assign link.headFlit  = fifo[rdPtr];
  assign link.headValid = (count != '0);
  assign isHead  = link.headValid && (link.headFlit.kind == flitPkg::HEAD);
  assign hdr     = link.headFlit.payload.hdr;
  // Zero length is taken as a single-flit packet
  assign headLen = (hdr.pktLength == '0) ? `LEN_W'(1) : hdr.pktLength;

  always_comb
  begin
    xyRoute = '0;
    if (hdr.destX > myX)
      xyRoute[portPkg::EAST] = 1'b1;
    else if (hdr.destX < myX)
      xyRoute[portPkg::WEST] = 1'b1;
    else if (hdr.destY > myY)
      xyRoute[portPkg::NORTH] = 1'b1;
    else if (hdr.destY < myY)
      xyRoute[portPkg::SOUTH] = 1'b1;
    else
      xyRoute[portPkg::LOCAL] = 1'b1;
  end

  // Route is held from the header pop until the last flit leaves
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      routeValid <= 1'b0;
      heldRoute  <= '0;
      remaining  <= '0;
    end
    else if (popNow)
    begin
      if (routeValid)
      begin
        remaining <= remaining - 1'b1;
        if (remaining == `LEN_W'(1))
          routeValid <= 1'b0;
      end
      else if (isHead && headLen > `LEN_W'(1))
      begin
        routeValid <= 1'b1;
        heldRoute  <= xyRoute;
        remaining  <= headLen - 1'b1;
      end
    end
  end

  assign link.routeReq  = routeValid ? heldRoute : (isHead ? xyRoute : '0);
  assign link.pktLength = routeValid ? remaining : (isHead ? headLen : '0);

endmodule

// ==== verilog/outputPort.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module outputPort (
  input  logic             clk,
  input  logic             rst,
  flitLink.dst             links [`NUM_PORTS],
  input  portPkg::portDir  myPort,
  output flitPkg::flit     outFlit,
  output logic             outValid,
  input  logic             outCredit,
  output portPkg::portVec  pop
);

  flitPkg::flit          headArr [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] validArr;
  portPkg::portVec       grant;
  flitPkg::flit          selFlit;
  logic                  selValid;
  logic                  moving;
  logic [`CREDIT_W-1:0]  credit;

  outputAllocator uAlloc (
    .clk    (clk),
    .rst    (rst),
    .links  (links),
    .myPort (myPort),
    .moving (moving),
    .grant  (grant)
  );

  genvar g;
  generate
    for (g = 0; g < `NUM_PORTS; g++)
    begin : genView
      assign headArr[g]  = links[g].headFlit;
      assign validArr[g] = links[g].headValid;
    end
  endgenerate

  // Crossbar column for this output
  always_comb
  begin
    selFlit  = '0;
    selValid = 1'b0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i])
      begin
        selFlit  = headArr[i];
        selValid = validArr[i];
      end
    end
  end

  // Granted head moves whenever downstream has room
  assign moving = selValid && (credit != '0);
  assign pop    = moving ? grant : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      credit   <= `CREDIT_W'(`BUF_DEPTH);
      outValid <= 1'b0;
    end
    else
    begin
      credit   <= credit - `CREDIT_W'(moving) + `CREDIT_W'(outCredit);
      outValid <= moving;
    end
  end

  always_ff @(posedge clk)
  begin
    if (moving)
      outFlit <= selFlit;
  end

endmodule

// ==== verilog/outputAllocator.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module outputAllocator (
  input  logic             clk,
  input  logic             rst,
  flitLink.dst             links [`NUM_PORTS],
  input  portPkg::portDir  myPort,
  input  logic             moving,
  output portPkg::portVec  grant
);

  localparam int N = `NUM_PORTS;

  // Bit 0 is idle, bit i+1 means input i holds this output
  logic [N:0]    state;
  logic [N:0]    nextState;
  logic [N-1:0]  req;
  logic [N-1:0]  cand;
  logic [N-1:0]  advance;
  logic [N-1:0]  leaseEnd;

  genvar g;
  generate
    for (g = 0; g < N; g++)
    begin : genLease
      assign req[g]     = links[g].routeReq[myPort];
      assign advance[g] = moving && state[g+1];
      // An input whose lease ends now only shows its old packet
      assign cand[g]    = req[g] && (links[g].pktLength != '0)
                          && !(state[g+1] && leaseEnd[g]);

      leaseCounter uLease (
        .clk       (clk),
        .rst       (rst),
        .headFlit  (links[g].headFlit),
        .headValid (links[g].headValid),
        .advance   (advance[g]),
        .leaseEnd  (leaseEnd[g])
      );
    end
  endgenerate

  // First requester in rotating order starting at start, idle if none
  function automatic logic [N:0] pickFrom(input logic [N-1:0] r, input int start);
    int          idx;
    logic [N:0]  s;
    s = (N+1)'(1);
    for (int k = N - 1; k >= 0; k--)
    begin
      idx = (start + k) % N;
      if (r[idx])
        s = (N+1)'(1) << (idx + 1);
    end
    return s;
  endfunction

  // ------------------------------------------------------------------------
  // Grant FSM
  // ------------------------------------------------------------------------
  always_comb
  begin
    nextState = pickFrom(cand, 0);
    if (!state[0])
    begin
      for (int i = 0; i < N; i++)
      begin
        if (state[i+1])
        begin
          if (req[i] && !leaseEnd[i])
            nextState = state;
          else
            nextState = pickFrom(cand, (i + 1) % N);
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= (N+1)'(1);
    else
      state <= nextState;
  end

  assign grant = state[N:1];

endmodule

// ==== verilog/leaseCounter.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

module leaseCounter (
  input  logic          clk,
  input  logic          rst,
  input  flitPkg::flit  headFlit,
  input  logic          headValid,
  input  logic          advance,
  output logic          leaseEnd
);

  logic               headSeen;
  logic [`LEN_W-1:0]  lenReg;
  logic [`LEN_W-1:0]  lenEff;
  logic [`LEN_W-1:0]  count;

  assign headSeen = headValid && (headFlit.kind == flitPkg::HEAD);

  // While the header is still at the head its own length applies
  assign lenEff   = headSeen ? headFlit.payload.hdr.pktLength : lenReg;
  assign leaseEnd = advance && (({1'b0, count} + 1'b1) >= {1'b0, lenEff});

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenReg <= '0;
      count  <= '0;
    end
    else
    begin
      if (headSeen)
        lenReg <= headFlit.payload.hdr.pktLength;
      if (leaseEnd)
        count <= '0;
      else if (advance)
        count <= count + 1'b1;
    end
  end

endmodule

// ==== verilog/flitLink.sv ====
`timescale 1ns/1ps
`include "router_cfg.svh"

// Head-of-buffer view of one input unit, seen by every output port
interface flitLink;

  flitPkg::flit        headFlit;
  logic                headValid;
  portPkg::portVec     routeReq;
  logic [`LEN_W-1:0]   pktLength;

  modport src (
    output headFlit, headValid, routeReq, pktLength
  );

  modport dst (
    input headFlit, headValid, routeReq, pktLength
  );

endinterface

// ==== verilog/portPkg.sv ====
`include "router_cfg.svh"

package portPkg;

  // Order doubles as the priority order out of the idle state
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portDir;

  // One bit per port, indexed by portDir
  typedef logic [`NUM_PORTS-1:0] portVec;

endpackage

// ==== verilog/flitPkg.sv ====
`include "router_cfg.svh"

package flitPkg;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    HEAD = 2'd1,
    BODY = 2'd2,
    TAIL = 2'd3
  } flitKind;

  // Header layout, destX in the top nibble
  typedef struct packed {
    logic [`COORD_W-1:0]                         destX;
    logic [`COORD_W-1:0]                         destY;
    logic [`LEN_W-1:0]                           pktLength;
    logic [`FLIT_DATA_W-2*`COORD_W-`LEN_W-1:0]   reserved;
  } headerFields;

  // Same 32 bits, read as header fields on a HEAD flit and as data otherwise
  typedef union packed {
    headerFields              hdr;
    logic [`FLIT_DATA_W-1:0]  data;
  } flitPayload;

  typedef struct packed {
    flitKind     kind;
    flitPayload  payload;
  } flit;

endpackage

// ==== verilog/router_cfg.svh ====
`ifndef ROUTER_CFG_SVH
`define ROUTER_CFG_SVH

// Flit payload and header field widths
`define FLIT_DATA_W 32
`define LEN_W       12
`define COORD_W     4

// Router geometry
`define NUM_PORTS   5

// Input buffer depth, also the initial credit count of every output
`define BUF_DEPTH   4
`define CREDIT_W    3

`endif
